//--- isaPkg.sv
`default_nettype none

package isaPkg;

    // primary opcodes
    typedef enum logic [5:0] {
        opSpecial = 6'h00,  // R-type, look at funct
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBle     = 6'h06,
        opBgt     = 6'h07,
        opAddi    = 6'h08,
        opAddiu   = 6'h09,
        opLb      = 6'h20,
        opLh      = 6'h21,
        opLw      = 6'h23,
        opSb      = 6'h28,
        opSh      = 6'h29,
        opSw      = 6'h2b
    } opcodeT;

    // R-type function codes
    typedef enum logic [5:0] {
        fnJr    = 6'h08,
        fnBreak = 6'h0d,
        fnRte   = 6'h13,
        fnMult  = 6'h18,
        fnAdd   = 6'h20
    } functT;

    typedef enum logic [4:0] {
        clsAdd, clsAddi, clsAddiu,
        clsLw, clsLh, clsLb, clsSw, clsSh, clsSb,
        clsBeq, clsBne, clsBgt, clsBle,
        clsJ, clsJal, clsJr, clsBreak, clsRte,
        clsMult, clsInvalid
    } instrClassT;

endpackage

`default_nettype wire

//--- ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [4:0] {
        stResetInit,
        stFetchPc, stFetchWait, stFetchIr, stDecode,
        stAluExec, stArithWrite, stOverflow, stInvalid,
        stExcWait, stExcRead, stExcJump,
        stMemAddr, stMemRead, stMemWait, stMemLoadMdr,
        stLoadWord, stLoadHalf, stLoadByte,
        stStoreWord, stStoreHalf, stStoreByte,
        stBranch, stJalLink, stJump, stJr, stBreak, stRte,
        stMultStart, stMultWait, stMultWrite
    } ctrlStateT;

    typedef enum logic [2:0] {
        pcAluResult  = 3'd0,
        pcAluOut     = 3'd1,  // branch target computed in decode
        pcJumpTarget = 3'd2,
        pcExcVector  = 3'd3,  // vector word read into MDR
        pcEpc        = 3'd4
    } pcSrcT;

    typedef enum logic [2:0] {
        aluLoadA   = 3'd0,
        aluAdd     = 3'd1,
        aluSub     = 3'd2,
        aluCompare = 3'd7
    } aluOpT;

    typedef enum logic [1:0] {
        srcBReg, srcBFour, srcBImm, srcBImmShift
    } aluSrcBT;

    typedef enum logic [2:0] {
        addrPc          = 3'd0,
        addrAluOut      = 3'd1,
        addrInvalidVec  = 3'd2,
        addrOverflowVec = 3'd3
    } iOrDT;

    typedef enum logic [1:0] {
        dstRt, dstRd, dstRa, dstSp
    } regDstT;

    typedef enum logic [3:0] {
        wbAluOut    = 4'd0,
        wbMdrWord   = 4'd1,
        wbMdrPart   = 4'd2,  // byte or half, sized by twoBytes
        wbPc        = 4'd6,
        wbStackInit = 4'd7
    } memToRegT;

    // branch compare select, high = eq / greater
    typedef enum logic [1:0] {
        cmpNone = 2'd0,
        cmpLow  = 2'd1,
        cmpHigh = 2'd2
    } cmpSelT;

endpackage

`default_nettype wire

//--- instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import isaPkg::*; (
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    output instrClassT instrClass
);

    always_comb begin
        instrClass = clsInvalid;
        case (opcode)
            opSpecial: begin
                case (funct)  // funct only matters for R-type
                    fnAdd:   instrClass = clsAdd;
                    fnJr:    instrClass = clsJr;
                    fnBreak: instrClass = clsBreak;
                    fnRte:   instrClass = clsRte;
                    fnMult:  instrClass = clsMult;
                    default: instrClass = clsInvalid;
                endcase
            end
            opAddi:  instrClass = clsAddi;
            opAddiu: instrClass = clsAddiu;
            opLw:    instrClass = clsLw;
            opLh:    instrClass = clsLh;
            opLb:    instrClass = clsLb;
            opSw:    instrClass = clsSw;
            opSh:    instrClass = clsSh;
            opSb:    instrClass = clsSb;
            opBeq:   instrClass = clsBeq;
            opBne:   instrClass = clsBne;
            opBgt:   instrClass = clsBgt;
            opBle:   instrClass = clsBle;
            opJ:     instrClass = clsJ;
            opJal:   instrClass = clsJal;
            default: instrClass = clsInvalid;  // unknown opcode raises the exception
        endcase
    end

endmodule

`default_nettype wire

//--- mainSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mainSequencer import isaPkg::*, ctrlPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  instrClassT instrClass,
    input  logic       overflow,
    input  logic       multDone,
    output ctrlStateT  state
);

    ctrlStateT nextState;

    always_ff @(posedge clk) begin
        if (rst)
            state <= stResetInit;
        else
            state <= nextState;
    end

    // class stays valid from decode until the next fetch
    always_comb begin
        nextState = state;
        case (state)
            stResetInit: nextState = stFetchPc;
            stFetchPc:   nextState = stFetchWait;
            stFetchWait: nextState = stFetchIr;
            stFetchIr:   nextState = stDecode;
            stDecode: begin
                case (instrClass)
                    clsAdd, clsAddi, clsAddiu:               nextState = stAluExec;
                    clsLw, clsLh, clsLb, clsSw, clsSh, clsSb: nextState = stMemAddr;
                    clsBeq, clsBne, clsBgt, clsBle:          nextState = stBranch;
                    clsJ:     nextState = stJump;
                    clsJal:   nextState = stJalLink;
                    clsJr:    nextState = stJr;
                    clsBreak: nextState = stBreak;
                    clsRte:   nextState = stRte;
                    clsMult:  nextState = stMultStart;
                    default:  nextState = stInvalid;
                endcase
            end
            stAluExec: begin
                if (overflow && instrClass != clsAddiu)  // addiu never traps
                    nextState = stOverflow;
                else
                    nextState = stArithWrite;
            end
            stOverflow, stInvalid: nextState = stExcWait;
            stExcWait: nextState = stExcRead;
            stExcRead: nextState = stExcJump;
            stMemAddr: nextState = (instrClass == clsSw) ? stStoreWord : stMemRead;
            stMemRead: nextState = stMemWait;
            stMemWait: nextState = stMemLoadMdr;
            stMemLoadMdr: begin
                case (instrClass)
                    clsLw:   nextState = stLoadWord;
                    clsLh:   nextState = stLoadHalf;
                    clsLb:   nextState = stLoadByte;
                    clsSh:   nextState = stStoreHalf;
                    default: nextState = stStoreByte;
                endcase
            end
            stJalLink:   nextState = stJump;
            stMultStart: nextState = stMultWait;
            stMultWait:  nextState = multDone ? stMultWrite : stMultWait;
            stArithWrite, stExcJump,
            stLoadWord, stLoadHalf, stLoadByte,
            stStoreWord, stStoreHalf, stStoreByte,
            stBranch, stJump, stJr, stBreak, stRte,
            stMultWrite: nextState = stFetchPc;
            default:     nextState = stResetInit;
        endcase
    end

endmodule

`default_nettype wire

//--- controlOutputs.sv
`timescale 1ns/1ps
`default_nettype none

module controlOutputs import isaPkg::*, ctrlPkg::*; (
    input  ctrlStateT  state,
    input  instrClassT instrClass,
    output logic       pcWriteCond,
    output logic       pcWrite,
    output logic       wdSrc,
    output logic       memWrite,
    output logic       irWrite,
    output logic       regWrite,
    output logic       regALoad,
    output logic       regBLoad,
    output logic       aluSrcA,
    output logic       epcWrite,
    output logic       aluOutSrc,
    output logic       aluOutWrite,
    output logic       twoBytes,
    output logic       store,
    output logic       hiLoSrc,
    output logic       hiLoWrite,
    output logic       mdrLoad,
    output logic       multInit,
    output cmpSelT     eqOrNe,
    output cmpSelT     gtOrLt,
    output pcSrcT      pcSrc,
    output aluOpT      aluOp,
    output aluSrcBT    aluSrcB,
    output iOrDT       iOrD,
    output regDstT     regDst,
    output memToRegT   memToReg
);

    always_comb begin
        pcWriteCond = 1'b0;
        pcWrite     = 1'b0;
        wdSrc       = 1'b0;
        memWrite    = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        regALoad    = 1'b0;
        regBLoad    = 1'b0;
        aluSrcA     = 1'b0;  // 0 = PC, 1 = reg A
        epcWrite    = 1'b0;
        aluOutSrc   = 1'b0;  // ALUOut only ever takes the ALU result
        aluOutWrite = 1'b0;
        twoBytes    = 1'b0;
        store       = 1'b0;
        hiLoSrc     = 1'b0;
        hiLoWrite   = 1'b0;
        mdrLoad     = 1'b0;
        multInit    = 1'b0;
        eqOrNe      = cmpNone;
        gtOrLt      = cmpNone;
        pcSrc       = pcAluResult;
        aluOp       = aluLoadA;
        aluSrcB     = srcBReg;
        iOrD        = addrPc;
        regDst      = dstRt;
        memToReg    = wbAluOut;

        case (state)
            stResetInit: begin
                regWrite = 1'b1;
                regDst   = dstSp;
                memToReg = wbStackInit;
            end
            stFetchPc: begin  // read at PC, PC += 4
                pcWrite = 1'b1;
                aluSrcB = srcBFour;
                aluOp   = aluAdd;
            end
            stFetchIr: irWrite = 1'b1;
            stDecode: begin
                regALoad    = 1'b1;
                regBLoad    = 1'b1;
                aluSrcB     = srcBImmShift;  // speculative branch target
                aluOp       = aluAdd;
                aluOutWrite = 1'b1;
            end
            stAluExec: begin
                aluSrcA     = 1'b1;
                aluSrcB     = (instrClass == clsAdd) ? srcBReg : srcBImm;
                aluOp       = aluAdd;
                aluOutWrite = 1'b1;
            end
            stArithWrite: begin
                regWrite = 1'b1;
                regDst   = (instrClass == clsAdd) ? dstRd : dstRt;
            end
            stOverflow, stInvalid: begin
                epcWrite = 1'b1;  // EPC gets PC - 4
                aluSrcB  = srcBFour;
                aluOp    = aluSub;
                iOrD     = (state == stOverflow) ? addrOverflowVec : addrInvalidVec;
            end
            stExcRead: mdrLoad = 1'b1;
            stExcJump: begin
                pcWrite = 1'b1;
                pcSrc   = pcExcVector;
            end
            stMemAddr: begin
                aluSrcA     = 1'b1;
                aluSrcB     = srcBImm;
                aluOp       = aluAdd;
                aluOutWrite = 1'b1;
            end
            stMemRead:    iOrD = addrAluOut;
            stMemLoadMdr: mdrLoad = 1'b1;
            stLoadWord: begin
                regWrite = 1'b1;
                memToReg = wbMdrWord;
            end
            stLoadHalf, stLoadByte: begin
                regWrite = 1'b1;
                memToReg = wbMdrPart;
                twoBytes = (state == stLoadHalf);
            end
            stStoreWord: begin
                memWrite = 1'b1;
                iOrD     = addrAluOut;
            end
            stStoreHalf, stStoreByte: begin  // merge into the word read back
                memWrite = 1'b1;
                iOrD     = addrAluOut;
                wdSrc    = 1'b1;
                store    = 1'b1;
                twoBytes = (state == stStoreHalf);
            end
            stBranch: begin
                aluSrcA     = 1'b1;
                pcSrc       = pcAluOut;
                pcWriteCond = 1'b1;
                case (instrClass)
                    clsBeq: begin
                        aluOp  = aluSub;
                        eqOrNe = cmpHigh;
                    end
                    clsBne: begin
                        aluOp  = aluSub;
                        eqOrNe = cmpLow;
                    end
                    clsBgt: begin
                        aluOp  = aluCompare;
                        gtOrLt = cmpHigh;
                    end
                    default: begin  // ble
                        aluOp  = aluCompare;
                        gtOrLt = cmpLow;
                    end
                endcase
            end
            stJalLink: begin
                regWrite = 1'b1;
                regDst   = dstRa;
                memToReg = wbPc;
            end
            stJump: begin
                pcWrite = 1'b1;
                pcSrc   = pcJumpTarget;
            end
            stJr: begin
                pcWrite = 1'b1;
                aluSrcA = 1'b1;  // pass rs straight through
            end
            stBreak: begin  // back to the break itself
                pcWrite = 1'b1;
                aluSrcB = srcBFour;
                aluOp   = aluSub;
            end
            stRte: begin
                pcWrite = 1'b1;
                pcSrc   = pcEpc;
            end
            stMultStart: multInit = 1'b1;
            stMultWrite: begin
                hiLoSrc   = 1'b1;
                hiLoWrite = 1'b1;
            end
            default: ;  // wait states
        endcase
    end

endmodule

`default_nettype wire

//--- multWaitTimer.sv
`timescale 1ns/1ps
`default_nettype none

module multWaitTimer #(
    parameter int multCycles = 33
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic multDone
);

    localparam int cntW = $clog2(multCycles + 1);

    logic [cntW-1:0] count;
    logic            busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= cntW'(multCycles - 1);  // last busy cycle hits zero
        end else if (busy) begin
            if (count == '0)
                busy <= 1'b0;
            else
                count <= count - 1'b1;
        end
    end

    assign multDone = busy && (count == '0);

endmodule

`default_nettype wire

//--- controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit import isaPkg::*, ctrlPkg::*; #(
    parameter int multCycles = 33
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       overflow,
    output logic       pcWriteCond,
    output logic       pcWrite,
    output logic       wdSrc,
    output logic       memWrite,
    output logic       irWrite,
    output logic       regWrite,
    output logic       regALoad,
    output logic       regBLoad,
    output logic       aluSrcA,
    output logic       epcWrite,
    output logic       aluOutSrc,
    output logic       aluOutWrite,
    output logic       twoBytes,
    output logic       store,
    output logic       hiLoSrc,
    output logic       hiLoWrite,
    output logic       mdrLoad,
    output logic       multInit,
    output cmpSelT     eqOrNe,
    output cmpSelT     gtOrLt,
    output pcSrcT      pcSrc,
    output aluOpT      aluOp,
    output aluSrcBT    aluSrcB,
    output iOrDT       iOrD,
    output regDstT     regDst,
    output memToRegT   memToReg
);

    instrClassT instrClass;
    ctrlStateT  state;
    logic       multDone;

    instrDecoder i_decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    mainSequencer i_sequencer (
        .clk        (clk),
        .rst        (rst),
        .instrClass (instrClass),
        .overflow   (overflow),
        .multDone   (multDone),
        .state      (state)
    );

    controlOutputs i_outputs (
        .state       (state),
        .instrClass  (instrClass),
        .pcWriteCond (pcWriteCond),
        .pcWrite     (pcWrite),
        .wdSrc       (wdSrc),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .regALoad    (regALoad),
        .regBLoad    (regBLoad),
        .aluSrcA     (aluSrcA),
        .epcWrite    (epcWrite),
        .aluOutSrc   (aluOutSrc),
        .aluOutWrite (aluOutWrite),
        .twoBytes    (twoBytes),
        .store       (store),
        .hiLoSrc     (hiLoSrc),
        .hiLoWrite   (hiLoWrite),
        .mdrLoad     (mdrLoad),
        .multInit    (multInit),
        .eqOrNe      (eqOrNe),
        .gtOrLt      (gtOrLt),
        .pcSrc       (pcSrc),
        .aluOp       (aluOp),
        .aluSrcB     (aluSrcB),
        .iOrD        (iOrD),
        .regDst      (regDst),
        .memToReg    (memToReg)
    );

    // multInit doubles as the timer start
    multWaitTimer #(
        .multCycles (multCycles)
    ) i_multTimer (
        .clk      (clk),
        .rst      (rst),
        .start    (multInit),
        .multDone (multDone)
    );

endmodule

`default_nettype wire

//--- tbControlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbControlUnit import isaPkg::*, ctrlPkg::*;;

    localparam int multCycles = 5;
    localparam int halfPeriod = 20;
    localparam int numDirected = 23;
    localparam int numRandom = 40;
    localparam int numInstr = numDirected + numRandom;
    localparam int maxLen = (6 + multCycles > 9) ? 6 + multCycles : 9;
    localparam int timeLimit = (numInstr * maxLen + 8) * 2 * halfPeriod;  // reset plus slack

    logic clk;
    logic rst;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic overflow;
    logic pcWriteCond, pcWrite, wdSrc, memWrite, irWrite, regWrite;
    logic regALoad, regBLoad, aluSrcA, epcWrite, aluOutSrc, aluOutWrite;
    logic twoBytes, store, hiLoSrc, hiLoWrite, mdrLoad, multInit;
    cmpSelT eqOrNe;
    cmpSelT gtOrLt;
    pcSrcT pcSrc;
    aluOpT aluOp;
    aluSrcBT aluSrcB;
    iOrDT iOrD;
    regDstT regDst;
    memToRegT memToReg;

    logic [16:0] lfsr;
    instrClassT clsQ[$];
    logic ovfQ[$];
    // bit 0 is hiLoWrite, bit 7 pcWrite, bit 15 aluOutSrc
    string enableName [0:15] = '{"hiLoWrite", "multInit", "pcWriteCond", "memWrite",
                                 "epcWrite", "regWrite", "irWrite", "pcWrite",
                                 "mdrLoad", "aluOutWrite", "regALoad", "regBLoad",
                                 "aluSrcA", "wdSrc", "hiLoSrc", "aluOutSrc"};

    controlUnit #(.multCycles(multCycles)) i_dut (.*);

    initial clk = 1'b0;
    always #(halfPeriod) clk = ~clk;

    function automatic logic lfsrStep();
        logic fb;
        fb = lfsr[16] ^ lfsr[13];  // x^17 + x^14 + 1
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    function automatic int randBits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++)
            v = (v << 1) | lfsrStep();
        return v;
    endfunction

    // cycle table, fetch through the next fetch
    function automatic int instrLength(input instrClassT c, input logic trap);
        case (c)
            clsAdd, clsAddi:         return trap ? 9 : 6;
            clsAddiu, clsSw, clsJal: return 6;
            clsInvalid:              return 8;
            clsLw, clsLh, clsLb, clsSh, clsSb: return 9;
            clsMult:                 return 6 + multCycles;
            default:                 return 5;
        endcase
    endfunction

    function automatic logic [15:0] expectedEnables(input instrClassT c, input logic trap,
                                                    input int off, input int len);
        logic [15:0] e;
        logic last;
        logic mem;
        e = 16'h0000;
        last = (off == len - 1);
        mem = (c == clsLw || c == clsLh || c == clsLb ||
               c == clsSw || c == clsSh || c == clsSb);
        e[7] = (off == 0);  // PC += 4 in fetch
        e[6] = (off == 2);
        e[10] = (off == 3);  // register reads in decode
        e[11] = (off == 3);
        e[9] = (off == 3);
        case (c)
            clsAdd, clsAddi, clsAddiu: begin
                e[4] = trap && off == 5;
                e[7] = e[7] | (trap && last);
                e[5] = !trap && last;
                e[8] = trap && off == 7;
                e[9] = e[9] | (off == 4);
                e[12] = (off == 4);
            end
            clsInvalid: begin
                e[4] = (off == 4);
                e[7] = e[7] | last;
                e[8] = (off == 6);
            end
            clsLw, clsLh, clsLb: begin
                e[5] = last;
                e[8] = (off == 7);
            end
            clsSw: e[3] = last;
            clsSh, clsSb: begin
                e[3] = last;
                e[8] = (off == 7);
                e[13] = last;  // merged write data
            end
            clsBeq, clsBne, clsBgt, clsBle: begin
                e[2] = last;
                e[12] = last;
            end
            clsJal: begin
                e[5] = (off == 4);
                e[7] = e[7] | last;
            end
            clsMult: begin
                e[1] = (off == 4);
                e[0] = (off == 5 + multCycles);
                e[14] = e[0];
            end
            clsJr: begin
                e[7] = e[7] | last;
                e[12] = last;
            end
            default: e[7] = e[7] | last;  // j, break, rte
        endcase
        if (mem) begin
            e[9] = e[9] | (off == 4);  // address into ALUOut
            e[12] = (off == 4);
        end
        return e;
    endfunction

    task automatic compareValue(input string name, input logic [7:0] act,
                                input logic [7:0] exp);
        assert (act === exp) else begin
            $display("error %s expected 0x%0h actual 0x%0h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic matchEnables(input logic [15:0] exp);
        logic [15:0] act;
        act = {aluOutSrc, hiLoSrc, wdSrc, aluSrcA, regBLoad, regALoad, aluOutWrite, mdrLoad,
               pcWrite, irWrite, regWrite, epcWrite, memWrite, pcWriteCond, multInit,
               hiLoWrite};
        for (int b = 0; b < 16; b++)
            compareValue(enableName[b], act[b], exp[b]);
    endtask

    task automatic auditSelects(input instrClassT c, input logic [15:0] exp, input int off);
        regDstT expDst;
        memToRegT expWb;
        if (off == 0) begin
            compareValue("pcSrc", pcSrc, pcAluResult);
            compareValue("iOrD", iOrD, addrPc);
            compareValue("aluSrcB", aluSrcB, srcBFour);
            compareValue("aluOp", aluOp, aluAdd);
        end else if (exp[7]) begin
            case (c)
                clsJ, clsJal:    compareValue("pcSrc", pcSrc, pcJumpTarget);
                clsRte:          compareValue("pcSrc", pcSrc, pcEpc);
                clsJr, clsBreak: ;
                default:         compareValue("pcSrc", pcSrc, pcExcVector);
            endcase
        end
        if (off == 3) begin  // branch target
            compareValue("aluSrcB", aluSrcB, srcBImmShift);
            compareValue("aluOp", aluOp, aluAdd);
        end
        if (off == 4 && exp[9]) begin
            compareValue("aluSrcB", aluSrcB, (c == clsAdd) ? srcBReg : srcBImm);
            compareValue("aluOp", aluOp, aluAdd);
        end
        if (off == 5 && (c == clsLw || c == clsLh || c == clsLb ||
                         c == clsSh || c == clsSb))
            compareValue("iOrD", iOrD, addrAluOut);
        if (exp[5]) begin
            expDst = (c == clsAdd) ? dstRd : (c == clsJal) ? dstRa : dstRt;
            expWb = (c == clsLw) ? wbMdrWord : (c == clsLh || c == clsLb) ? wbMdrPart :
                    (c == clsJal) ? wbPc : wbAluOut;
            compareValue("regDst", regDst, expDst);
            compareValue("memToReg", memToReg, expWb);
            if (c == clsLh || c == clsLb)
                compareValue("twoBytes", twoBytes, c == clsLh);
        end
        if (exp[4]) begin  // EPC gets PC - 4
            compareValue("iOrD", iOrD, (c == clsInvalid) ? addrInvalidVec : addrOverflowVec);
            compareValue("aluSrcB", aluSrcB, srcBFour);
            compareValue("aluOp", aluOp, aluSub);
        end
        if (exp[3]) begin
            compareValue("iOrD", iOrD, addrAluOut);
            compareValue("store", store, c != clsSw);
            compareValue("twoBytes", twoBytes, c == clsSh);
        end
        if (exp[2]) begin
            compareValue("pcSrc", pcSrc, pcAluOut);
            compareValue("aluOp", aluOp,
                         (c == clsBeq || c == clsBne) ? aluSub : aluCompare);
            compareValue("eqOrNe", eqOrNe,
                         (c == clsBeq) ? cmpHigh : (c == clsBne) ? cmpLow : cmpNone);
            compareValue("gtOrLt", gtOrLt,
                         (c == clsBgt) ? cmpHigh : (c == clsBle) ? cmpLow : cmpNone);
        end
    endtask

    task automatic driveInstr(input instrClassT c, input logic ovf, input logic alt);
        opcode = opSpecial;
        funct = 6'h3f;  // unused funct
        overflow = ovf;
        case (c)
            clsAdd:   funct = fnAdd;
            clsJr:    funct = fnJr;
            clsBreak: funct = fnBreak;
            clsRte:   funct = fnRte;
            clsMult:  funct = fnMult;
            clsAddi:  opcode = opAddi;
            clsAddiu: opcode = opAddiu;
            clsLw:    opcode = opLw;
            clsLh:    opcode = opLh;
            clsLb:    opcode = opLb;
            clsSw:    opcode = opSw;
            clsSh:    opcode = opSh;
            clsSb:    opcode = opSb;
            clsBeq:   opcode = opBeq;
            clsBne:   opcode = opBne;
            clsBgt:   opcode = opBgt;
            clsBle:   opcode = opBle;
            clsJ:     opcode = opJ;
            clsJal:   opcode = opJal;
            default:  opcode = alt ? 6'h3f : opSpecial;  // bad opcode or bad funct
        endcase
    endtask

    initial begin
        #(timeLimit);
        $display("watchdog expired before the instruction list finished");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        instrClassT cls;
        logic ovf;
        logic trap;
        int len;
        logic [15:0] exp;
        rst = 1'b1;
        opcode = 6'h00;
        funct = 6'h00;
        overflow = 1'b0;
        lfsr = 17'd91077;
        for (int k = 0; k < 20; k++) begin  // every class once
            clsQ.push_back(instrClassT'(k));
            ovfQ.push_back(1'b0);
        end
        clsQ.push_back(clsAdd);
        clsQ.push_back(clsAddi);
        clsQ.push_back(clsAddiu);
        repeat (3) ovfQ.push_back(1'b1);
        for (int k = 0; k < numRandom; k++) begin
            clsQ.push_back(instrClassT'(randBits(5) % 20));
            ovfQ.push_back(lfsrStep());
        end

        @(posedge clk);  // state still unknown here
        repeat (3) begin
            @(posedge clk);
            matchEnables(16'h0020);
        end
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        matchEnables(16'h0020);  // stack pointer init
        compareValue("regDst", regDst, dstSp);
        compareValue("memToReg", memToReg, wbStackInit);

        for (int i = 0; i < numInstr; i++) begin
            cls = clsQ[i];
            ovf = ovfQ[i];
            trap = ovf && (cls == clsAdd || cls == clsAddi);
            len = instrLength(cls, trap);
            for (int off = 0; off < len; off++) begin
                @(posedge clk);
                exp = expectedEnables(cls, trap, off, len);
                matchEnables(exp);
                auditSelects(cls, exp, off);
                if (off == 1) begin
                    @(negedge clk);  // IR loads in this cycle
                    driveInstr(cls, ovf, lfsrStep());
                end
            end
        end
        @(posedge clk);
        matchEnables(16'h0080);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
isaPkg.sv
ctrlPkg.sv
instrDecoder.sv
mainSequencer.sv
controlOutputs.sv
multWaitTimer.sv
controlUnit.sv
tbControlUnit.sv
